// File: Bender.yml
package:
  name: executeStage

sources:
  - logic/execPkg.sv
  - logic/idExIf.sv
  - logic/aluDatapath.sv
  - logic/branchResolve.sv
  - logic/exMemRegister.sv
  - logic/executeStage.sv
  - target: test
    files:
      - verification/executeChecker.sv
      - verification/executeStageTb.sv

// File: executeStage.f
logic/execPkg.sv
logic/idExIf.sv
logic/aluDatapath.sv
logic/branchResolve.sv
logic/exMemRegister.sv
logic/executeStage.sv
verification/executeChecker.sv
verification/executeStageTb.sv

// File: logic/aluDatapath.sv
module aluDatapath (
    idExIf.alu              ex,
    output execPkg::word_t  aluResult,
    output logic            illegalOp
);
    import execPkg::*;

    word_t       opA;
    word_t       opB;
    logic [3:0]  shAmt;
    logic [16:0] carrySum;
    logic [31:0] rolWide;
    logic [31:0] rorWide;
    word_t       revA;
    word_t       stuAddr;

    assign opA = ex.rd1;

    // second operand mux
    assign opB = ex.aluSrc ? ex.imm : ex.rd2;

    // rotates and shifts only look at the low nibble
    assign shAmt = opB[3:0];

    // shared adder, bit 16 is the carry for SCO
    assign carrySum = {1'b0, opA} + {1'b0, opB};

    // rotate by shifting a doubled copy
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    // store-with-update address always uses the immediate
    assign stuAddr = ex.rd1 + ex.imm;

    always_comb begin
        for (int i = 0; i < $bits(word_t); i++) begin
            revA[i] = opA[$bits(word_t) - 1 - i];
        end
    end

    always_comb begin
        illegalOp = 1'b0;
        case (ex.aluOp)
            ADD: begin
                aluResult = carrySum[15:0];
            end
            SUB: begin
                aluResult = opA - opB;
            end
            XOR: begin
                aluResult = opA ^ opB;
            end
            ANDN: begin
                aluResult = opA & ~opB;
            end
            ROL: begin
                aluResult = rolWide[31:16];
            end
            SLL: begin
                aluResult = opA << shAmt;
            end
            ROR: begin
                aluResult = rorWide[15:0];
            end
            SRL: begin
                aluResult = opA >> shAmt;
            end
            SEQ: begin
                aluResult = word_t'(opA == opB);
            end
            SLT: begin
                aluResult = word_t'($signed(opA) < $signed(opB));
            end
            SLE: begin
                aluResult = word_t'($signed(opA) <= $signed(opB));
            end
            SCO: begin
                aluResult = word_t'(carrySum[16]);
            end
            BTR: begin
                aluResult = revA;
            end
            SLBI: begin
                // upper byte load, immediate fills the low byte
                aluResult = (opA << 8) | ex.imm;
            end
            LBI: begin
                aluResult = ex.imm;
            end
            STU: begin
                aluResult = stuAddr;
            end
            LINK: begin
                aluResult = ex.pc2;
            end
            default: begin
                aluResult = '0;
                illegalOp = 1'b1;
            end
        endcase
    end

endmodule

// File: logic/branchResolve.sv
module branchResolve (
    idExIf.branch           ex,
    output logic            taken,
    output execPkg::word_t  nextPc
);
    import execPkg::*;

    logic  rsZero;
    logic  rsNeg;
    word_t targetBase;
    word_t target;

    // condition flags on the first operand
    assign rsZero = (ex.rd1 == '0);
    assign rsNeg  = ex.rd1[$bits(word_t) - 1];

    always_comb begin
        case (ex.branchKind)
            BEQZ: begin
                taken = rsZero;
            end
            BNEZ: begin
                taken = ~rsZero;
            end
            BLTZ: begin
                taken = rsNeg;
            end
            BGEZ: begin
                taken = ~rsNeg;
            end
            JUMP, JUMPREG: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // register-relative only for JUMPREG
    assign targetBase = (ex.branchKind == JUMPREG) ? ex.rd1 : ex.pc2;
    assign target     = targetBase + ex.imm;

    // fall through to the sequential pc otherwise
    assign nextPc = taken ? target : ex.pc2;

endmodule

// File: logic/exMemRegister.sv
module exMemRegister (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  execPkg::word_t      aluResult,
    input  execPkg::word_t      storeData,
    input  execPkg::word_t      nextPc,
    input  logic                taken,
    input  logic                regWrite,
    input  logic                memWrite,
    input  logic                memRead,
    input  logic                memToReg,
    input  logic                halt,
    input  logic                dump,
    input  execPkg::regAddr_t   writeReg,
    output logic                redirect,
    output execPkg::word_t      aluResultMem,
    output execPkg::word_t      storeDataMem,
    output execPkg::word_t      nextPcMem,
    output execPkg::regAddr_t   writeRegMem,
    output logic                regWriteMem,
    output logic                memWriteMem,
    output logic                memReadMem,
    output logic                memToRegMem,
    output logic                haltMem,
    output logic                dumpMem,
    output logic                takenMem
);

    logic squash;

    // instruction in EX is on the wrong path after a registered transfer
    assign squash = takenMem;

    assign redirect = taken & ~squash;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluResultMem <= '0;
            storeDataMem <= '0;
            nextPcMem    <= '0;
            writeRegMem  <= '0;
            regWriteMem  <= 1'b0;
            memWriteMem  <= 1'b0;
            memReadMem   <= 1'b0;
            memToRegMem  <= 1'b0;
            haltMem      <= 1'b0;
            dumpMem      <= 1'b0;
            takenMem     <= 1'b0;
        end else if (!stall) begin
            aluResultMem <= aluResult;
            storeDataMem <= storeData;
            nextPcMem    <= nextPc;
            writeRegMem  <= writeReg;
            // side effects killed for a squashed instruction
            regWriteMem  <= regWrite & ~squash;
            memWriteMem  <= memWrite & ~squash;
            memReadMem   <= memRead & ~squash;
            haltMem      <= halt & ~squash;
            memToRegMem  <= memToReg;
            dumpMem      <= dump;
            takenMem     <= redirect;
        end
    end

endmodule

// File: logic/execPkg.sv
package execPkg;

    // data word: operands, immediates, program counters, results
    typedef logic [15:0] word_t;

    // destination register number, eight registers
    typedef logic [2:0] regAddr_t;

    // ALU operations, encodings not listed here are illegal
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        XOR  = 5'd2,
        ANDN = 5'd3,
        ROL  = 5'd4,
        SLL  = 5'd5,
        ROR  = 5'd6,
        SRL  = 5'd7,
        SEQ  = 5'd8,
        SLT  = 5'd9,
        SLE  = 5'd10,
        SCO  = 5'd11,
        BTR  = 5'd12,
        SLBI = 5'd13,
        LBI  = 5'd14,
        STU  = 5'd15,
        LINK = 5'd16
    } aluOpE;

    // control transfer kinds
    // conditional ones test the first operand
    typedef enum logic [2:0] {
        NONE    = 3'd0,
        BEQZ    = 3'd1,
        BNEZ    = 3'd2,
        BLTZ    = 3'd3,
        BGEZ    = 3'd4,
        JUMP    = 3'd5,
        JUMPREG = 3'd6
    } branchKindE;

endpackage

// File: logic/executeStage.sv
module executeStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stall,
    input  execPkg::word_t       rd1,
    input  execPkg::word_t       rd2,
    input  execPkg::word_t       imm,
    input  execPkg::word_t       pc2,
    input  execPkg::aluOpE       aluOp,
    input  logic                 aluSrc,
    input  execPkg::branchKindE  branchKind,
    input  logic                 regWrite,
    input  logic                 memWrite,
    input  logic                 memRead,
    input  logic                 memToReg,
    input  logic                 halt,
    input  logic                 dump,
    input  execPkg::regAddr_t    writeReg,
    output logic                 redirect,
    output logic                 err,
    output execPkg::word_t       aluResultMem,
    output execPkg::word_t       storeDataMem,
    output execPkg::word_t       nextPcMem,
    output execPkg::regAddr_t    writeRegMem,
    output logic                 regWriteMem,
    output logic                 memWriteMem,
    output logic                 memReadMem,
    output logic                 memToRegMem,
    output logic                 haltMem,
    output logic                 dumpMem,
    output logic                 takenMem
);
    import execPkg::*;

    word_t aluResult;
    word_t nextPc;
    logic  illegalOp;
    logic  taken;

    idExIf idEx ();

    // ID/EX fields onto the shared bundle
    assign idEx.rd1        = rd1;
    assign idEx.rd2        = rd2;
    assign idEx.imm        = imm;
    assign idEx.pc2        = pc2;
    assign idEx.aluOp      = aluOp;
    assign idEx.aluSrc     = aluSrc;
    assign idEx.branchKind = branchKind;

    aluDatapath alu (
        .ex        (idEx.alu),
        .aluResult (aluResult),
        .illegalOp (illegalOp)
    );

    branchResolve branchUnit (
        .ex     (idEx.branch),
        .taken  (taken),
        .nextPc (nextPc)
    );

    assign err = illegalOp;

    // rd2 goes down the pipe as store data
    exMemRegister exMem (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .aluResult    (aluResult),
        .storeData    (rd2),
        .nextPc       (nextPc),
        .taken        (taken),
        .regWrite     (regWrite),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memToReg     (memToReg),
        .halt         (halt),
        .dump         (dump),
        .writeReg     (writeReg),
        .redirect     (redirect),
        .aluResultMem (aluResultMem),
        .storeDataMem (storeDataMem),
        .nextPcMem    (nextPcMem),
        .writeRegMem  (writeRegMem),
        .regWriteMem  (regWriteMem),
        .memWriteMem  (memWriteMem),
        .memReadMem   (memReadMem),
        .memToRegMem  (memToRegMem),
        .haltMem      (haltMem),
        .dumpMem      (dumpMem),
        .takenMem     (takenMem)
    );

endmodule

// File: logic/idExIf.sv
interface idExIf;
    import execPkg::*;

    // operand fields
    word_t rd1;
    word_t rd2;
    word_t imm;
    word_t pc2;

    // control fields
    aluOpE      aluOp;
    logic       aluSrc;
    branchKindE branchKind;

    // ID/EX register side
    modport driver (
        output rd1,
        output rd2,
        output imm,
        output pc2,
        output aluOp,
        output aluSrc,
        output branchKind
    );

    modport alu (
        input rd1,
        input rd2,
        input imm,
        input pc2,
        input aluOp,
        input aluSrc
    );

    // branch unit only needs rs and the target inputs
    modport branch (
        input rd1,
        input imm,
        input pc2,
        input branchKind
    );

endinterface

// File: verification/executeChecker.sv
module executeChecker (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               redirect,
    input  logic               err,
    input  execPkg::word_t     aluResultMem,
    input  execPkg::word_t     storeDataMem,
    input  execPkg::word_t     nextPcMem,
    input  execPkg::regAddr_t  writeRegMem,
    // regWrite, memWrite, memRead, memToReg, halt, dump, taken
    input  logic [6:0]         ctrlMem,
    input  logic               expRedirect,
    input  logic               expErr,
    input  execPkg::word_t     expAluResult,
    input  execPkg::word_t     expStoreData,
    input  execPkg::word_t     expNextPc,
    input  execPkg::regAddr_t  expWriteReg,
    input  logic [6:0]         expCtrl,
    input  logic [4:0]         opTag,
    input  logic [2:0]         kindTag,
    output int                 passCount,
    output int                 failCount
);
    import execPkg::*;

    word_t      heldAlu;
    word_t      heldStore;
    word_t      heldNextPc;
    regAddr_t   heldWriteReg;
    logic [6:0] heldCtrl;
    logic [4:0] heldOp;
    logic [2:0] heldKind;
    logic       haveExp = 1'b0;
    logic       fresh = 1'b0;
    logic       resetSeen = 1'b0;
    int         errsNow = 0;

    initial begin
        passCount = 0;
        failCount = 0;
    end

    function automatic string describeInstr(input logic [4:0] op, input logic [2:0] kind);
        return $sformatf("op %0d kind %0d", op, kind);
    endfunction

    task automatic compareField(input string testName, input string field,
                                input logic [15:0] expVal, input logic [15:0] actVal);
        if (actVal !== expVal) begin
            $display("Mismatch test %0d (%s) %s: expected 0x%h, actual 0x%h",
                     passCount + failCount, testName, field, expVal, actVal);
            errsNow++;
        end
    endtask

    task automatic compareMem(input string testName, input word_t alu, input word_t store,
                              input word_t pc, input regAddr_t wr, input logic [6:0] ctrl);
        compareField(testName, "aluResultMem", alu, aluResultMem);
        compareField(testName, "storeDataMem", store, storeDataMem);
        compareField(testName, "nextPcMem", pc, nextPcMem);
        compareField(testName, "writeRegMem", wr, writeRegMem);
        compareField(testName, "control bits", ctrl, ctrlMem);
    endtask

    task automatic reportTest(input string name);
        int id;
        id = passCount + failCount;
        if (errsNow == 0) begin
            passCount++;
            $display("test %0d %s: ok", id, name);
        end else begin
            failCount++;
            $display("test %0d %s: failed with %0d errors", id, name, errsNow);
        end
        errsNow = 0;
    endtask

    // what the DUT should register at this edge
    always @(posedge clk) begin
        if (rstN && !stall) begin
            heldAlu      <= expAluResult;
            heldStore    <= expStoreData;
            heldNextPc   <= expNextPc;
            heldWriteReg <= expWriteReg;
            heldCtrl     <= expCtrl;
            heldOp       <= opTag;
            heldKind     <= kindTag;
            haveExp      <= 1'b1;
            fresh        <= 1'b1;
        end else begin
            fresh <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rstN && !resetSeen) begin
            compareMem("reset", '0, '0, '0, '0, '0);
            reportTest("reset");
            resetSeen = 1'b1;
        end else if (rstN && haveExp) begin
            // while stalled this checks that the outputs hold
            compareMem(describeInstr(heldOp, heldKind), heldAlu, heldStore, heldNextPc,
                       heldWriteReg, heldCtrl);
            if (fresh) begin
                reportTest(describeInstr(heldOp, heldKind));
            end
        end
        // same-cycle outputs of the instruction now in EX
        if (rstN) begin
            compareField(describeInstr(opTag, kindTag), "redirect", expRedirect, redirect);
            compareField(describeInstr(opTag, kindTag), "err", expErr, err);
        end
    end

endmodule

// File: verification/executeStageTb.sv
module executeStageTb;
    import execPkg::*;

    localparam int aluTests = 2 * 17 + 2;
    localparam int branchTests = 7 * 3;
    localparam int randomTests = 60;
    localparam int numInstr = aluTests + branchTests + randomTests;
    // one issue edge plus up to three stalled edges
    localparam int cyclesPerTest = 4;
    localparam int watchdogTime = (numInstr + 1) * cyclesPerTest * 20 + 400;

    typedef struct packed {
        logic       redirect;
        logic       err;
        word_t      aluResult;
        word_t      storeData;
        word_t      nextPc;
        regAddr_t   writeReg;
        logic [6:0] ctrl;
    } expected_t;

    logic       clk;
    logic       rstN;
    logic       stall;
    word_t      rd1, rd2, imm, pc2;
    aluOpE      aluOp;
    logic       aluSrc;
    branchKindE branchKind;
    logic       regWrite, memWrite, memRead, memToReg, halt, dump;
    regAddr_t   writeReg;
    logic       redirect, err;
    word_t      aluResultMem, storeDataMem, nextPcMem;
    regAddr_t   writeRegMem;
    logic       regWriteMem, memWriteMem, memReadMem, memToRegMem;
    logic       haltMem, dumpMem, takenMem;

    logic [15:0] lfsr = 16'd18;
    expected_t   expNow;
    logic        expTakenMem;
    int          passCount, failCount;

    executeStage uut (.*);

    executeChecker chk (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .redirect     (redirect),
        .err          (err),
        .aluResultMem (aluResultMem),
        .storeDataMem (storeDataMem),
        .nextPcMem    (nextPcMem),
        .writeRegMem  (writeRegMem),
        .ctrlMem      ({regWriteMem, memWriteMem, memReadMem, memToRegMem,
                        haltMem, dumpMem, takenMem}),
        .expRedirect  (expNow.redirect),
        .expErr       (expNow.err),
        .expAluResult (expNow.aluResult),
        .expStoreData (expNow.storeData),
        .expNextPc    (expNow.nextPc),
        .expWriteReg  (expNow.writeReg),
        .expCtrl      (expNow.ctrl),
        .opTag        (aluOp),
        .kindTag      (branchKind),
        .passCount    (passCount),
        .failCount    (failCount)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], nextBit()};
        end
        return r;
    endfunction

    // ctrlIn is {regWrite, memWrite, memRead, memToReg, halt, dump}
    function automatic expected_t refModel(input word_t a, input word_t b2, input word_t im,
                                           input word_t pc, input logic [4:0] op,
                                           input logic src, input logic [2:0] kind,
                                           input logic [5:0] ctrlIn, input regAddr_t wr,
                                           input logic prevTaken);
        expected_t   e;
        word_t       b;
        int          sh;
        logic [16:0] wide;
        logic        take;
        b = src ? im : b2;
        sh = b[3:0];
        wide = {1'b0, a} + {1'b0, b};
        e = '0;
        case (op)
            ADD:  e.aluResult = a + b;
            SUB:  e.aluResult = a - b;
            XOR:  e.aluResult = a ^ b;
            ANDN: e.aluResult = a & ~b;
            ROL:  e.aluResult = (a << sh) | (a >> (16 - sh));
            SLL:  e.aluResult = a << sh;
            ROR:  e.aluResult = (a >> sh) | (a << (16 - sh));
            SRL:  e.aluResult = a >> sh;
            SEQ:  e.aluResult = (a == b) ? 16'd1 : 16'd0;
            SLT:  e.aluResult = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            SLE:  e.aluResult = ($signed(a) <= $signed(b)) ? 16'd1 : 16'd0;
            SCO:  e.aluResult = {15'd0, wide[16]};
            BTR: begin
                for (int i = 0; i < 16; i++) begin
                    e.aluResult[i] = a[15 - i];
                end
            end
            SLBI: e.aluResult = (a << 8) | im;
            LBI:  e.aluResult = im;
            STU:  e.aluResult = a + im;
            LINK: e.aluResult = pc;
            default: e.err = 1'b1;
        endcase
        case (kind)
            BEQZ:          take = (a == 16'd0);
            BNEZ:          take = (a != 16'd0);
            BLTZ:          take = a[15];
            BGEZ:          take = !a[15];
            JUMP, JUMPREG: take = 1'b1;
            default:       take = 1'b0;
        endcase
        e.nextPc = take ? (((kind == JUMPREG) ? a : pc) + im) : pc;
        // previous transfer taken, so this one is on the wrong path
        e.redirect = take & ~prevTaken;
        e.storeData = b2;
        e.writeReg = wr;
        e.ctrl = {ctrlIn[5] & ~prevTaken, ctrlIn[4] & ~prevTaken, ctrlIn[3] & ~prevTaken,
                  ctrlIn[2], ctrlIn[1] & ~prevTaken, ctrlIn[0], e.redirect};
        return e;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always_comb begin
        expNow = refModel(rd1, rd2, imm, pc2, aluOp, aluSrc, branchKind,
                          {regWrite, memWrite, memRead, memToReg, halt, dump},
                          writeReg, expTakenMem);
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            expTakenMem <= 1'b0;
        end else if (!stall) begin
            expTakenMem <= expNow.ctrl[0];
        end
    end

    // issue one instruction, optionally held by a stall span
    task automatic driveInstr(input word_t a, input word_t b, input word_t im, input word_t pc,
                              input logic [4:0] op, input logic src, input logic [2:0] kind,
                              input logic [5:0] ctrl, input int span);
        rd1        <= a;
        rd2        <= b;
        imm        <= im;
        pc2        <= pc;
        aluOp      <= aluOpE'(op);
        aluSrc     <= src;
        branchKind <= branchKindE'(kind);
        {regWrite, memWrite, memRead, memToReg, halt, dump} <= ctrl;
        writeReg   <= takeBits(3);
        stall      <= (span > 0);
        if (span > 0) begin
            repeat (span) @(posedge clk);
            stall <= 1'b0;
        end
        @(posedge clk);
    endtask

    initial begin
        logic [4:0] op;
        logic [2:0] kind;
        word_t      a;
        int         span;
        rstN = 1'b0;
        stall = 1'b0;
        rd1 = '0;
        rd2 = '0;
        imm = '0;
        pc2 = '0;
        aluOp = ADD;
        aluSrc = 1'b0;
        branchKind = NONE;
        {regWrite, memWrite, memRead, memToReg, halt, dump} = '0;
        writeReg = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        // every ALU op with both sources, then two illegal encodings
        for (int i = 0; i < aluTests; i++) begin
            if (i < 34) begin
                op = i / 2;
            end else if (i == 34) begin
                op = 5'd17;
            end else begin
                op = 5'd31;
            end
            driveInstr(takeBits(16), takeBits(16), takeBits(16), takeBits(16) & 16'hFFFE,
                       op, i[0], 3'd0, takeBits(6), 0);
        end
        // each kind against zero, positive and negative rd1
        for (int k = 0; k < 7; k++) begin
            for (int c = 0; c < 3; c++) begin
                if (c == 0) begin
                    a = '0;
                end else if (c == 1) begin
                    a = takeBits(15) | 16'd1;
                end else begin
                    a = takeBits(15) | 16'h8000;
                end
                driveInstr(a, takeBits(16), takeBits(16), takeBits(16) & 16'hFFFE,
                           takeBits(4), takeBits(1), k, 6'b111111, 0);
            end
        end
        // mixed traffic with random stalls
        for (int i = 0; i < randomTests; i++) begin
            if (takeBits(3) == 0) begin
                op = takeBits(5);
            end else begin
                op = takeBits(5) % 17;
            end
            kind = takeBits(3);
            if (kind == 3'd7) begin
                kind = 3'd0;
            end
            span = (takeBits(2) == 0) ? 1 + takeBits(2) % 3 : 0;
            driveInstr(takeBits(16), takeBits(16), takeBits(16), takeBits(16) & 16'hFFFE,
                       op, takeBits(1), kind, takeBits(6), span);
        end
        wait (passCount + failCount >= numInstr + 1);
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("watchdog expired: the tests did not finish within %0d time units",
                 watchdogTime);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
